// ==== files.f ====
+incdir+common
+incdir+tests
common/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_wb_stage.sv
hdl/cpu_core.sv
tests/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build the cpu_core testbench with Verilator and run it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_cpu_core -o tb_cpu_core \
    && ./obj_dir/tb_cpu_core > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// MIPS primary opcodes and function codes
localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_BEQ     = 6'h04;
localparam logic [5:0] OPC_BNE     = 6'h05;
localparam logic [5:0] OPC_ADDIU   = 6'h09;
localparam logic [5:0] OPC_LUI     = 6'h0f;
localparam logic [5:0] OPC_LW      = 6'h23;
localparam logic [5:0] OPC_SW      = 6'h2b;
localparam logic [5:0] FUN_ADDU    = 6'h21;
localparam logic [5:0] FUN_SUBU    = 6'h23;
localparam logic [5:0] FUN_AND     = 6'h24;
localparam logic [5:0] FUN_OR      = 6'h25;
localparam logic [5:0] FUN_SLT     = 6'h2a;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
        err_count++;
    end
endtask

// ISA-level run of imem on a copy of dmem, returns the executed instruction count
function automatic int run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] val;
    logic [4:0]  dst;
    logic        wr;
    bit          done;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = 32'd0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
        ref_dmem[i[7:0]] = dmem[i[7:0]];
        touched[i[7:0]]  = 1'b0;
    end
    exp_pc.delete();
    exp_reg.delete();
    exp_val.delete();
    pc    = 32'd0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 2000) begin
        ins  = imem[pc[9:2]];
        a    = regs[ins[25:21]];
        b    = regs[ins[20:16]];
        imm  = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        dst  = ins[20:16];
        wr   = 1'b1;
        val  = 32'd0;
        next = pc + 32'd4;
        case (ins[31:26])
            OPC_SPECIAL: begin
                dst = ins[15:11];
                case (ins[5:0])
                    FUN_ADDU: val = a + b;
                    FUN_SUBU: val = a - b;
                    FUN_AND:  val = a & b;
                    FUN_OR:   val = a | b;
                    FUN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  wr = 1'b0;
                endcase
            end
            OPC_ADDIU: val = a + imm;
            OPC_LUI:   val = {ins[15:0], 16'h0000};
            OPC_LW:    val = ref_dmem[addr[9:2]];
            OPC_SW: begin
                wr = 1'b0;
                ref_dmem[addr[9:2]] = b;
                touched[addr[9:2]]  = 1'b1;
            end
            OPC_BEQ, OPC_BNE: begin
                wr = 1'b0;
                if ((ins[31:26] == OPC_BEQ) ? (a == b) : (a != b)) begin
                    next = pc + 32'd4 + {imm[29:0], 2'b00};
                    done = (next == pc);  // branch to itself ends the program
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            regs[dst] = val;
            exp_pc.push_back(pc);
            exp_reg.push_back({27'd0, dst});
            exp_val.push_back(val);
        end
        pc = next;
        steps++;
    end
    return steps;
endfunction

`endif

// ==== tests/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

    localparam int          MEM_WORDS = 256;
    localparam logic [31:0] SELF_LOOP = 32'h1000_ffff;  // beq r0, r0, -1

    logic        clk = 1'b0;
    logic        rst_n_i = 1'b0;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] ref_dmem [MEM_WORDS];
    bit          touched [MEM_WORDS];
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_reg [$];
    logic [31:0] exp_val [$];
    int          seen = 0;         // trace writes observed in this test
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          budget = 10;      // cycles before the first program loads
    int          cycle_count = 0;

    `include "tb_ref_model.svh"

    always #20 clk = ~clk;

    cpu_core uut (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .inst_sram_en_o      (inst_sram_en),
        .inst_sram_addr_o    (inst_sram_addr),
        .inst_sram_rdata_i   (inst_sram_rdata),
        .data_sram_en_o      (data_sram_en),
        .data_sram_wen_o     (data_sram_wen),
        .data_sram_addr_o    (data_sram_addr),
        .data_sram_wdata_o   (data_sram_wdata),
        .data_sram_rdata_i   (data_sram_rdata),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[9:2]];  // read before write
            if (data_sram_wen != 4'b0000) begin
                dmem[data_sram_addr[9:2]] = data_sram_wdata;
            end
        end
    end

    // trace comparison on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rst_n_i && debug_wb_rf_wen != 4'b0000) begin
            if (seen < exp_val.size()) begin
                check_equal({28'd0, debug_wb_rf_wen}, 32'h0000_000f, "trace write enable");
                check_equal(debug_wb_pc, exp_pc[seen], "trace pc");
                check_equal({27'd0, debug_wb_rf_wnum}, exp_reg[seen], "trace register");
                check_equal(debug_wb_rf_wdata, exp_val[seen], "trace value");
            end else begin
                $display("extra register write to r%0d at pc %h after the expected trace",
                         debug_wb_rf_wnum, debug_wb_pc);
                err_count++;
            end
            seen++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > budget) begin
            $display("timeout: the run went past its budget of %0d cycles", budget);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // r1..r7 seeded, then 60 alu, load and store words over r0..r7 and words 0..7
    task automatic random_program();
        logic [31:0] x;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] off;
        x = 32'd62;
        for (int r = 1; r < 8; r++) begin
            x = xorshift32(x);
            prog.push_back(i_type(OPC_ADDIU, r[4:0], 5'd0, x[15:0]));
        end
        for (int k = 0; k < 60; k++) begin
            x   = xorshift32(x);
            rd  = {2'b00, x[5:3]};
            rs  = {2'b00, x[8:6]};
            rt  = {2'b00, x[11:9]};
            off = {11'd0, x[14:12], 2'b00};
            case (x[2:0])
                3'd0: prog.push_back(r_type(FUN_ADDU, rd, rs, rt));
                3'd1: prog.push_back(r_type(FUN_SUBU, rd, rs, rt));
                3'd2: prog.push_back(r_type(FUN_AND, rd, rs, rt));
                3'd3: prog.push_back(r_type(FUN_OR, rd, rs, rt));
                3'd4: prog.push_back(r_type(FUN_SLT, rd, rs, rt));
                3'd5: prog.push_back(i_type(x[15] ? OPC_LUI : OPC_ADDIU, rd, rs, x[31:16]));
                3'd6: prog.push_back(i_type(OPC_LW, rd, 5'd0, off));
                default: prog.push_back(i_type(OPC_SW, rt, 5'd0, off));
            endcase
        end
        prog.push_back(SELF_LOOP);
    endtask

    task automatic run_test(input string name);
        int steps;
        int n;
        int waited;
        int errs_before;
        @(negedge clk);
        rst_n_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i[7:0]] = (i < prog.size()) ? prog[i] : 32'h0;
            dmem[i[7:0]] = 32'h0;
        end
        steps       = run_reference();
        budget      = budget + steps * 3 + 50;
        n           = exp_val.size();
        seen        = 0;
        errs_before = err_count;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        waited  = 0;
        while (seen < n && waited < steps * 3 + 20) begin
            @(posedge clk);
            waited++;
        end
        if (seen < n) begin
            $display("%s: only %0d of %0d register writes were retired", name, seen, n);
            err_count++;
        end
        repeat (20) @(posedge clk);
        @(negedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (touched[i[7:0]]) begin
                check_equal(dmem[i[7:0]], ref_dmem[i[7:0]], "data word");
            end
        end
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s passed, %0d register writes", name, n);
        end else begin
            tests_failed++;
            $display("test %s FAILED with %0d errors", name, err_count - errs_before);
        end
        prog.delete();
    endtask

    initial begin
        // alu and immediate ops
        prog.push_back(i_type(OPC_ADDIU, 5'd1, 5'd0, 16'h1234));
        prog.push_back(i_type(OPC_ADDIU, 5'd2, 5'd0, 16'hfffb));
        prog.push_back(i_type(OPC_LUI, 5'd3, 5'd0, 16'hdead));
        prog.push_back(i_type(OPC_ADDIU, 5'd4, 5'd0, 16'h00ff));
        prog.push_back(r_type(FUN_ADDU, 5'd5, 5'd1, 5'd2));
        prog.push_back(r_type(FUN_SUBU, 5'd6, 5'd1, 5'd2));
        prog.push_back(r_type(FUN_AND, 5'd7, 5'd1, 5'd4));
        prog.push_back(r_type(FUN_OR, 5'd8, 5'd3, 5'd4));
        prog.push_back(r_type(FUN_SLT, 5'd9, 5'd2, 5'd1));
        prog.push_back(r_type(FUN_SLT, 5'd10, 5'd1, 5'd2));
        prog.push_back(SELF_LOOP);
        run_test("alu");
        // dependencies at distance one, two and three
        prog.push_back(i_type(OPC_ADDIU, 5'd1, 5'd0, 16'd5));
        prog.push_back(i_type(OPC_ADDIU, 5'd2, 5'd1, 16'd3));
        prog.push_back(r_type(FUN_ADDU, 5'd3, 5'd2, 5'd1));
        prog.push_back(r_type(FUN_SUBU, 5'd4, 5'd3, 5'd1));
        prog.push_back(i_type(OPC_ADDIU, 5'd5, 5'd2, 16'd1));
        prog.push_back(r_type(FUN_OR, 5'd6, 5'd4, 5'd3));
        prog.push_back(SELF_LOOP);
        run_test("forward");
        // stores, loads, load-use and load then branch
        prog.push_back(i_type(OPC_ADDIU, 5'd1, 5'd0, 16'h0011));
        prog.push_back(i_type(OPC_ADDIU, 5'd2, 5'd0, 16'h0022));
        prog.push_back(i_type(OPC_SW, 5'd1, 5'd0, 16'd0));
        prog.push_back(i_type(OPC_SW, 5'd2, 5'd0, 16'd4));
        prog.push_back(i_type(OPC_LW, 5'd3, 5'd0, 16'd0));
        prog.push_back(r_type(FUN_ADDU, 5'd4, 5'd3, 5'd2));
        prog.push_back(i_type(OPC_LW, 5'd5, 5'd0, 16'd4));
        prog.push_back(i_type(OPC_SW, 5'd5, 5'd0, 16'd8));
        prog.push_back(i_type(OPC_LW, 5'd6, 5'd0, 16'd8));
        prog.push_back(i_type(OPC_ADDIU, 5'd7, 5'd6, 16'd1));
        prog.push_back(i_type(OPC_SW, 5'd7, 5'd0, 16'd12));
        prog.push_back(i_type(OPC_LW, 5'd8, 5'd0, 16'd0));
        prog.push_back(i_type(OPC_BEQ, 5'd1, 5'd8, 16'd1));
        prog.push_back(i_type(OPC_ADDIU, 5'd9, 5'd0, 16'h0099));  // skipped
        prog.push_back(i_type(OPC_ADDIU, 5'd10, 5'd0, 16'h00aa));
        prog.push_back(SELF_LOOP);
        run_test("memory");
        // backward loop, taken and not-taken branches
        prog.push_back(i_type(OPC_ADDIU, 5'd1, 5'd0, 16'd3));
        prog.push_back(i_type(OPC_ADDIU, 5'd2, 5'd0, 16'd0));
        prog.push_back(r_type(FUN_ADDU, 5'd2, 5'd2, 5'd1));
        prog.push_back(i_type(OPC_ADDIU, 5'd1, 5'd1, 16'hffff));
        prog.push_back(i_type(OPC_BNE, 5'd0, 5'd1, 16'hfffd));  // back to the addu
        prog.push_back(i_type(OPC_BEQ, 5'd0, 5'd1, 16'd1));
        prog.push_back(i_type(OPC_ADDIU, 5'd3, 5'd0, 16'h0055));  // skipped
        prog.push_back(i_type(OPC_BNE, 5'd2, 5'd2, 16'd1));
        prog.push_back(i_type(OPC_ADDIU, 5'd4, 5'd0, 16'h0066));
        prog.push_back(i_type(OPC_BEQ, 5'd2, 5'd1, 16'd1));
        prog.push_back(i_type(OPC_ADDIU, 5'd5, 5'd0, 16'h0077));
        prog.push_back(SELF_LOOP);
        run_test("branch");
        // writes to r0 are dropped and r0 reads as zero
        prog.push_back(i_type(OPC_ADDIU, 5'd0, 5'd0, 16'h0123));
        prog.push_back(r_type(FUN_ADDU, 5'd1, 5'd0, 5'd0));
        prog.push_back(i_type(OPC_ADDIU, 5'd2, 5'd0, 16'd9));
        prog.push_back(r_type(FUN_OR, 5'd0, 5'd2, 5'd2));
        prog.push_back(r_type(FUN_ADDU, 5'd3, 5'd0, 5'd2));
        prog.push_back(i_type(OPC_SW, 5'd2, 5'd0, 16'd0));
        prog.push_back(i_type(OPC_LW, 5'd0, 5'd0, 16'd0));
        prog.push_back(r_type(FUN_ADDU, 5'd4, 5'd0, 5'd2));
        prog.push_back(SELF_LOOP);
        run_test("zero_reg");
        random_program();
        run_test("random");
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire         clk,
    input  wire         rst_n_i,
    output logic        inst_sram_en_o,
    output logic [31:0] inst_sram_addr_o,
    input  wire  [31:0] inst_sram_rdata_i,
    output logic        data_sram_en_o,
    output logic [3:0]  data_sram_wen_o,
    output logic [31:0] data_sram_addr_o,
    output logic [31:0] data_sram_wdata_o,
    input  wire  [31:0] data_sram_rdata_i,
    output logic [31:0] debug_wb_pc_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output logic [4:0]  debug_wb_rf_wnum_o,
    output logic [31:0] debug_wb_rf_wdata_o
);

    import cpu_pkg::*;

    logic        stall;
    logic        redirect;
    logic [31:0] target;
    logic        if_valid;
    logic [31:0] if_pc;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_t         wb;

    fetch_stage u_fetch (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall),
        .redirect_i       (redirect),
        .target_i         (target),
        .inst_sram_en_o   (inst_sram_en_o),
        .inst_sram_addr_o (inst_sram_addr_o),
        .if_valid_o       (if_valid),
        .if_pc_o          (if_pc)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .instr_i    (inst_sram_rdata_i),
        .if_valid_i (if_valid),
        .if_pc_i    (if_pc),
        .redirect_i (redirect),
        .wb_i       (wb),
        .id_ex_o    (id_ex),
        .stall_o    (stall)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .id_ex_i    (id_ex),
        .wb_i       (wb),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect),
        .target_o   (target)
    );

    memory_wb_stage u_memory_wb (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .ex_mem_i          (ex_mem),
        .data_sram_rdata_i (data_sram_rdata_i),
        .data_sram_en_o    (data_sram_en_o),
        .data_sram_wen_o   (data_sram_wen_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wdata_o (data_sram_wdata_o),
        .wb_o              (wb)
    );

    assign debug_wb_pc_o       = wb.pc;
    assign debug_wb_rf_wen_o   = {4{wb.wen}};  // byte enables all follow the word write
    assign debug_wb_rf_wnum_o  = wb.dest;
    assign debug_wb_rf_wdata_o = wb.data;

endmodule

`default_nettype wire

// ==== hdl/memory_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_wb_stage (
    input  wire                clk,
    input  wire                rst_n_i,
    input  cpu_pkg::ex_mem_t   ex_mem_i,
    input  wire         [31:0] data_sram_rdata_i,
    output logic               data_sram_en_o,
    output logic        [3:0]  data_sram_wen_o,
    output logic        [31:0] data_sram_addr_o,
    output logic        [31:0] data_sram_wdata_o,
    output cpu_pkg::wb_t       wb_o
);

    import cpu_pkg::*;

    ex_mem_t mem_wb_q;

    // whole-word accesses only
    assign data_sram_en_o    = ex_mem_i.valid && (ex_mem_i.mem_read || ex_mem_i.mem_write);
    assign data_sram_wen_o   = {4{ex_mem_i.valid && ex_mem_i.mem_write}};
    assign data_sram_addr_o  = ex_mem_i.result;
    assign data_sram_wdata_o = ex_mem_i.store_data;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_wb_q.valid <= 1'b0;
        end else begin
            mem_wb_q <= ex_mem_i;
        end
    end

    always_comb begin
        wb_o.valid = mem_wb_q.valid;
        wb_o.pc    = mem_wb_q.pc;
        wb_o.dest  = mem_wb_q.dest;
        wb_o.wen   = mem_wb_q.valid && mem_wb_q.reg_write && mem_wb_q.dest != '0;  // r0 dropped
        wb_o.data  = mem_wb_q.mem_read ? data_sram_rdata_i : mem_wb_q.result;
    end

    a_wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        data_sram_wen_o != 4'b0000 |-> data_sram_en_o)
        else $error("data sram write without enable");

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                clk,
    input  wire                rst_n_i,
    input  cpu_pkg::id_ex_t    id_ex_i,
    input  cpu_pkg::wb_t       wb_i,
    output cpu_pkg::ex_mem_t   ex_mem_o,
    output logic               redirect_o,
    output logic        [31:0] target_o
);

    import cpu_pkg::*;

    ex_mem_t     ex_mem_d;
    ex_mem_t     ex_mem_q;
    logic        mem_fwd_ok;
    logic        mem_hit_a;
    logic        mem_hit_b;
    logic        wb_hit_a;
    logic        wb_hit_b;
    logic [31:0] op_a;
    logic [31:0] op_b;   // rt value and store data
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic        equal;

    // loads are resolved through the stall, never from this stage
    assign mem_fwd_ok = ex_mem_q.valid && ex_mem_q.reg_write && !ex_mem_q.mem_read &&
                        ex_mem_q.dest != '0;
    assign mem_hit_a  = mem_fwd_ok && ex_mem_q.dest == id_ex_i.rs;
    assign mem_hit_b  = mem_fwd_ok && ex_mem_q.dest == id_ex_i.rt;
    assign wb_hit_a   = wb_i.valid && wb_i.wen && wb_i.dest == id_ex_i.rs;
    assign wb_hit_b   = wb_i.valid && wb_i.wen && wb_i.dest == id_ex_i.rt;

    assign op_a  = mem_hit_a ? ex_mem_q.result : (wb_hit_a ? wb_i.data : id_ex_i.rs_val);
    assign op_b  = mem_hit_b ? ex_mem_q.result : (wb_hit_b ? wb_i.data : id_ex_i.rt_val);
    assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: alu_y = op_a + alu_b;
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
            ALU_LUI: alu_y = {alu_b[15:0], 16'd0};
            default: alu_y = 32'd0;
        endcase
    end

    assign equal      = (op_a == op_b);
    assign redirect_o = id_ex_i.valid &&
                        ((id_ex_i.branch == BR_EQ && equal) ||
                         (id_ex_i.branch == BR_NE && !equal));
    assign target_o   = id_ex_i.pc + 32'd4 + {id_ex_i.imm[29:0], 2'b00};

    always_comb begin
        ex_mem_d.valid      = id_ex_i.valid;
        ex_mem_d.pc         = id_ex_i.pc;
        ex_mem_d.result     = alu_y;
        ex_mem_d.store_data = op_b;
        ex_mem_d.dest       = id_ex_i.dest;
        ex_mem_d.reg_write  = id_ex_i.reg_write;
        ex_mem_d.mem_read   = id_ex_i.mem_read;
        ex_mem_d.mem_write  = id_ex_i.mem_write;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_q.valid <= 1'b0;
        end else begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign ex_mem_o = ex_mem_q;

    // decode stalls every reader of a load result so a load never sits here beside one
    a_mem_fwd_not_load: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ex_mem_q.valid && ex_mem_q.mem_read && ex_mem_q.dest != '0 && id_ex_i.valid &&
         id_ex_i.alu_op != ALU_LUI &&
         (id_ex_i.reg_write || id_ex_i.mem_write || id_ex_i.branch != BR_NONE))
        |-> (ex_mem_q.dest != id_ex_i.rs &&
             (ex_mem_q.dest != id_ex_i.rt || (id_ex_i.use_imm && !id_ex_i.mem_write))))
        else $error("memory stage forward picked a load result");

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module decode_stage (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire         [31:0] instr_i,
    input  wire                if_valid_i,
    input  wire         [31:0] if_pc_i,
    input  wire                redirect_i,
    input  cpu_pkg::wb_t       wb_i,
    output cpu_pkg::id_ex_t    id_ex_o,
    output logic               stall_o
);

    import cpu_pkg::*;

    logic [31:0] rf [`CPU_NUM_REGS];
    logic [31:0] instr;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic        use_rs;
    logic        use_rt;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;

    // register read with same-cycle writeback bypass
    function automatic logic [31:0] rf_read(input reg_idx_t idx);
        if (idx == '0) begin
            return 32'd0;
        end
        if (wb_i.valid && wb_i.wen && wb_i.dest == idx) begin
            return wb_i.data;
        end
        return rf[idx];
    endfunction

    assign instr = if_valid_i ? instr_i : `CPU_NOP;  // rdata may be stale
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];

    always_comb begin
        id_ex_d        = '0;
        use_rs         = 1'b0;
        use_rt         = 1'b0;
        id_ex_d.pc     = if_pc_i;
        id_ex_d.rs     = rs;
        id_ex_d.rt     = rt;
        id_ex_d.rs_val = rf_read(rs);
        id_ex_d.rt_val = rf_read(rt);
        id_ex_d.imm    = {{16{instr[15]}}, instr[15:0]};
        id_ex_d.dest   = rt;
        id_ex_d.alu_op = ALU_ADD;
        id_ex_d.branch = BR_NONE;
        case (opcode_e'(instr[31:26]))
            OP_SPECIAL: begin
                id_ex_d.dest      = rd;
                id_ex_d.reg_write = 1'b1;
                use_rs            = 1'b1;
                use_rt            = 1'b1;
                case (funct_e'(instr[5:0]))
                    FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    FN_AND:  id_ex_d.alu_op = ALU_AND;
                    FN_OR:   id_ex_d.alu_op = ALU_OR;
                    FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    default: id_ex_d.reg_write = 1'b0;  // sll nop and the rest
                endcase
            end
            OP_ADDIU: begin
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                use_rs            = 1'b1;
            end
            OP_LUI: begin
                id_ex_d.alu_op    = ALU_LUI;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            OP_LW: begin
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.mem_read  = 1'b1;
                use_rs            = 1'b1;
            end
            OP_SW: begin
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.mem_write = 1'b1;
                use_rs            = 1'b1;
                use_rt            = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                id_ex_d.branch = (instr[26]) ? BR_NE : BR_EQ;
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            default: ;  // unknown opcode retires as a nop
        endcase
        id_ex_d.valid = if_valid_i && !redirect_i;
    end

    // load in execute feeding a source read now
    assign stall_o = if_valid_i && id_ex_q.valid && id_ex_q.mem_read &&
                     ((use_rs && rs == id_ex_q.dest) || (use_rt && rt == id_ex_q.dest));

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.wen) begin
            rf[wb_i.dest] <= wb_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
        end else begin
            id_ex_q       <= id_ex_d;
            id_ex_q.valid <= id_ex_d.valid && !stall_o;  // bubble carries valid low
        end
    end

    assign id_ex_o = id_ex_q;

    // a load and a branch cannot sit in execute together
    a_no_stall_and_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(stall_o && redirect_i && if_valid_i))
        else $error("stall and redirect on the same instruction at pc %h", if_pc_i);

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module fetch_stage (
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire         stall_i,
    input  wire         redirect_i,
    input  wire  [31:0] target_i,
    output logic        inst_sram_en_o,
    output logic [31:0] inst_sram_addr_o,
    output logic        if_valid_o,
    output logic [31:0] if_pc_o
);

    logic [31:0] pc_q;
    logic        if_valid_q;
    logic [31:0] if_pc_q;

    // sram read is dropped on stall so rdata keeps the stalled word
    assign inst_sram_en_o   = !stall_i;
    assign inst_sram_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= `CPU_RESET_PC;
            if_valid_q <= 1'b0;
        end else if (redirect_i) begin
            pc_q       <= target_i;
            if_valid_q <= 1'b0;  // word in flight is on the wrong path
        end else if (!stall_i) begin
            pc_q       <= pc_q + 32'd4;
            if_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if_pc_q <= pc_q;  // lines up with rdata
        end
    end

    assign if_valid_o = if_valid_q;
    assign if_pc_o    = if_pc_q;

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_sram_en_o |-> inst_sram_addr_o[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", inst_sram_addr_o);

endmodule

`default_nettype wire

// ==== common/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;        // sign extended
        reg_idx_t    dest;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        branch_e     branch;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] store_data;
        reg_idx_t    dest;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } ex_mem_t;

    // retirement record
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        reg_idx_t    dest;
        logic        wen;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`define CPU_NUM_REGS 32  // general purpose registers

// all-zero word decodes as sll r0, r0, 0
`define CPU_NOP 32'h0000_0000

`endif
